// ==== src/predecPkg.sv ====
`default_nettype none

package predecPkg;

  // ******************************
  // Bundle geometry
  // ******************************

  localparam int parcelCount = 15; // Parcels in one fetch bundle.
  localparam int parcelWidth = 16;
  localparam int maxParcels  = 5;  // Longest instruction in parcels.
  localparam int instrSlots  = 12;
  localparam int jumpSlots   = 4;
  localparam int offWidth    = 4;
  localparam int cntWidth    = 5;  // Holds a count of 0 to 15 starts.

  // ******************************
  // Class vector bit positions
  // ******************************

  localparam int clsJump    = 0;
  localparam int clsIndir   = 1;
  localparam int clsAlu     = 2;
  localparam int clsShift   = 3;
  localparam int clsMul     = 4;
  localparam int clsLoad    = 5;
  localparam int clsStore   = 6;
  localparam int clsStore2  = 7; // Second store port, indexed stores only.
  localparam int clsSys     = 8;
  localparam int classWidth = 9;

  // Main opcodes that are decoded by value rather than by range.
  localparam logic [7:0] opUncondJump = 8'd181;
  localparam logic [7:0] opIndirGroup = 8'd182; // Bits 15 to 13 select the variant.
  localparam logic [7:0] opSys        = 8'd255;

  // ******************************
  // Types
  // ******************************

  typedef logic [parcelCount-1:0][parcelWidth-1:0] parcelVec;

  typedef logic [classWidth-1:0] classVec;

  typedef logic [maxParcels-1:0][parcelWidth-1:0] instrWord;

  typedef struct packed {
    instrWord                instr;
    logic [maxParcels-2:0]   magic; // End bits of the first four parcels.
    logic [offWidth-1:0]     off;
    classVec                 cls;
  } predecSlot;

  typedef struct packed {
    parcelVec                parcels;
    logic [parcelCount-1:0]  endBits;
    logic [offWidth-1:0]     startOff;
  } bundleIn;

endpackage

`default_nettype wire

// ==== src/predecBoundary.sv ====
`timescale 1ns/1ps
`default_nettype none

module predecBoundary import predecPkg::*; (
  input  logic                   clk,
  input  logic                   arstN,
  input  logic                   inValid,
  input  bundleIn                inBundle,
  output logic                   stageValid,
  output bundleIn                stageBundle,
  output logic [parcelCount-1:0] startMark,
  output logic [cntWidth-1:0]    startCount,
  output logic                   badOffset
);

  logic [parcelCount+maxParcels-2:0] endExt;
  logic [parcelCount-1:0]            isStart;
  logic [parcelCount-1:0]            isComplete;

  // ******************************
  // Stage 1 register
  // ******************************

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      stageValid <= 1'b0;
    end else begin
      stageValid <= inValid;
    end
  end

  always_ff @(posedge clk) begin
    stageBundle <= inBundle;
  end

  // ******************************
  // Start detection
  // ******************************

  // End bits past the last parcel read as clear.
  assign endExt = {{(maxParcels-1){1'b0}}, stageBundle.endBits};

  always_comb begin
    isStart[0] = (stageBundle.startOff == '0);
    for (int p = 1; p < parcelCount; p++) begin
      isStart[p] = (stageBundle.startOff == offWidth'(p)) ||
                   ((stageBundle.startOff < offWidth'(p)) && stageBundle.endBits[p-1]);
    end
  end

  always_comb begin
    for (int p = 0; p < parcelCount; p++) begin
      isComplete[p] = |endExt[p +: maxParcels]; // Instruction ends inside the bundle.
    end
  end

  assign startMark = isStart & isComplete;

  assign startCount = cntWidth'($countones(startMark));

  assign badOffset = (stageBundle.startOff == offWidth'(parcelCount));

endmodule

`default_nettype wire

// ==== src/predecClassify.sv ====
`timescale 1ns/1ps
`default_nettype none

module predecClassify import predecPkg::*; (
  input  instrWord              instr,
  input  logic [maxParcels-2:0] magic,
  output classVec               cls
);

  logic [7:0] opMain;
  logic [5:0] opSub;
  logic [2:0] indirSel;
  logic       isLong;

  assign opMain   = instr[0][7:0];
  assign opSub    = instr[0][5:0];
  assign indirSel = instr[0][15:13];
  assign isLong   = ~magic[0]; // A set end bit on the first parcel means a short form.

  // ******************************
  // Long form decode
  // ******************************

  classVec longCls;

  always_comb begin
    longCls = '0;
    case (opMain) inside
      [8'd0:8'd39]: begin
        longCls[clsMul] = opMain[2];
        longCls[clsAlu] = ~opMain[2];
      end
      [8'd40:8'd45]: begin
        longCls[clsShift] = 1'b1;
      end
      [8'd46:8'd53]: begin
        longCls[clsAlu] = 1'b1;
      end
      [8'd64:8'd159]: begin
        longCls[clsLoad]   = ~opMain[0];
        longCls[clsStore]  = opMain[0];
        longCls[clsStore2] = opMain[0] && (opMain >= 8'd112); // Indexed range.
      end
      [8'd160:8'd175]: begin
        longCls[clsJump] = 1'b1; // Compare and branch.
        longCls[clsAlu]  = 1'b1;
      end
      opUncondJump: begin
        longCls[clsJump] = 1'b1;
      end
      opIndirGroup: begin
        longCls[clsJump]  = 1'b1;
        longCls[clsIndir] = (indirSel == 3'd0) || (indirSel == 3'd3);
      end
      opSys: begin
        longCls[clsSys] = 1'b1;
      end
      default: begin
        longCls = '0;
      end
    endcase
  end

  // ******************************
  // Short form decode
  // ******************************

  classVec shortCls;

  always_comb begin
    shortCls = '0;
    case (opSub) inside
      [6'd0:6'd19]: begin
        shortCls[clsAlu] = 1'b1;
      end
      [6'd20:6'd31]: begin
        shortCls[clsShift] = opSub[0]; // Only the odd codes are shifts.
      end
      [6'd48:6'd51]: begin
        shortCls[clsJump] = 1'b1;
      end
      default: begin
        shortCls = '0;
      end
    endcase
  end

  assign cls = isLong ? longCls : shortCls;

endmodule

`default_nettype wire

// ==== src/slotPicker.sv ====
`timescale 1ns/1ps
`default_nettype none

module slotPicker import predecPkg::*; #(
  parameter type payloadT  = logic,
  parameter int  slotCount = 1
) (
  input  logic [parcelCount-1:0] mark,
  input  payloadT                payload [parcelCount],
  output payloadT                slot    [slotCount],
  output logic [slotCount-1:0]   slotEn,
  output logic                   overflow
);

  logic [cntWidth-1:0] rank [parcelCount];
  logic [cntWidth-1:0] total;

  // Rank of a position is the number of marked positions below it.
  always_comb begin
    total = '0;
    for (int p = 0; p < parcelCount; p++) begin
      rank[p] = total;
      total   = total + cntWidth'(mark[p]);
    end
  end

  always_comb begin
    for (int s = 0; s < slotCount; s++) begin
      slot[s] = '0;
      for (int p = 0; p < parcelCount; p++) begin
        if (mark[p] && (rank[p] == cntWidth'(s))) begin
          slot[s] = payload[p];
        end
      end
    end
  end

  always_comb begin
    for (int s = 0; s < slotCount; s++) begin
      slotEn[s] = (total > cntWidth'(s));
    end
  end

  assign overflow = (total > cntWidth'(slotCount)); // Some rank reached slotCount.

endmodule

`default_nettype wire

// ==== src/predecResult.sv ====
`timescale 1ns/1ps
`default_nettype none

module predecResult import predecPkg::*; (
  input  logic                  clk,
  input  logic                  arstN,
  input  logic                  stageValid,
  input  predecSlot             instrSlotD [instrSlots],
  input  logic [instrSlots-1:0] instrEnD,
  input  predecSlot             jumpSlotD  [jumpSlots],
  input  logic [jumpSlots-1:0]  jumpEnD,
  input  logic                  badOffset,
  input  logic                  instrOverflow,
  input  logic                  jumpOverflow,
  output logic                  outValid,
  output predecSlot             instrSlot  [instrSlots],
  output logic [instrSlots-1:0] instrEn,
  output predecSlot             jumpSlot   [jumpSlots],
  output logic [jumpSlots-1:0]  jumpEn,
  output logic                  hasJumps,
  output logic                  error,
  output logic                  jumpError
);

  // ******************************
  // Stage 2 register
  // ******************************

  // Enables and flags only assert alongside outValid.
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      outValid  <= 1'b0;
      instrEn   <= '0;
      jumpEn    <= '0;
      hasJumps  <= 1'b0;
      error     <= 1'b0;
      jumpError <= 1'b0;
    end else begin
      outValid  <= stageValid;
      instrEn   <= stageValid ? instrEnD : '0;
      jumpEn    <= stageValid ? jumpEnD : '0;
      hasJumps  <= stageValid && ((|jumpEnD) || jumpOverflow);
      error     <= stageValid && (badOffset || instrOverflow);
      jumpError <= stageValid && jumpOverflow;
    end
  end

  always_ff @(posedge clk) begin
    instrSlot <= instrSlotD;
    jumpSlot  <= jumpSlotD;
  end

endmodule

`default_nettype wire

// ==== src/predecTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module predecTop import predecPkg::*; (
  input  logic                  clk,
  input  logic                  arstN,
  input  logic                  inValid,
  input  bundleIn               inBundle,
  output logic                  outValid,
  output predecSlot             instrSlot [instrSlots],
  output logic [instrSlots-1:0] instrEn,
  output predecSlot             jumpSlot  [jumpSlots],
  output logic [jumpSlots-1:0]  jumpEn,
  output logic                  hasJumps,
  output logic                  error,
  output logic                  jumpError
);

  logic                                               stageValid;
  bundleIn                                            stageBundle;
  logic [parcelCount-1:0]                             startMark;
  logic [cntWidth-1:0]                                startCount;
  logic                                               badOffset;
  logic [parcelCount+maxParcels-2:0][parcelWidth-1:0] parcelExt;
  logic [parcelCount+maxParcels-2:0]                  endExt;
  classVec                                            parcelCls [parcelCount];
  logic [parcelCount-1:0]                             jumpBits;
  predecSlot                                          payload   [parcelCount];
  predecSlot                                          instrSlotD [instrSlots];
  logic [instrSlots-1:0]                              instrEnD;
  predecSlot                                          jumpSlotD [jumpSlots];
  logic [jumpSlots-1:0]                               jumpEnD;
  logic                                               instrOverflow;
  logic                                               jumpOverflow;

  predecBoundary uBoundary (
    .clk        (clk),
    .arstN      (arstN),
    .inValid    (inValid),
    .inBundle   (inBundle),
    .stageValid (stageValid),
    .stageBundle(stageBundle),
    .startMark  (startMark),
    .startCount (startCount),
    .badOffset  (badOffset)
  );

  // Parcels and end bits beyond the bundle read as zero.
  assign parcelExt = {{(maxParcels-1)*parcelWidth{1'b0}}, stageBundle.parcels};
  assign endExt    = {{(maxParcels-1){1'b0}}, stageBundle.endBits};

  // ******************************
  // Per-parcel decode
  // ******************************

  for (genvar p = 0; p < parcelCount; p++) begin : gParcel
    predecClassify uClassify (
      .instr(parcelExt[p +: maxParcels]),
      .magic(endExt[p +: maxParcels-1]),
      .cls  (parcelCls[p])
    );

    assign jumpBits[p] = parcelCls[p][clsJump];

    assign payload[p] = '{
      instr: parcelExt[p +: maxParcels],
      magic: endExt[p +: maxParcels-1],
      off:   offWidth'(p),
      cls:   parcelCls[p]
    };
  end

  slotPicker #(
    .payloadT (predecSlot),
    .slotCount(instrSlots)
  ) uInstrPick (
    .mark    (startMark),
    .payload (payload),
    .slot    (instrSlotD),
    .slotEn  (instrEnD),
    .overflow()
  );

  slotPicker #(
    .payloadT (predecSlot),
    .slotCount(jumpSlots)
  ) uJumpPick (
    .mark    (startMark & jumpBits),
    .payload (payload),
    .slot    (jumpSlotD),
    .slotEn  (jumpEnD),
    .overflow(jumpOverflow)
  );

  assign instrOverflow = (startCount > cntWidth'(instrSlots));

  predecResult uResult (
    .clk          (clk),
    .arstN        (arstN),
    .stageValid   (stageValid),
    .instrSlotD   (instrSlotD),
    .instrEnD     (instrEnD),
    .jumpSlotD    (jumpSlotD),
    .jumpEnD      (jumpEnD),
    .badOffset    (badOffset),
    .instrOverflow(instrOverflow),
    .jumpOverflow (jumpOverflow),
    .outValid     (outValid),
    .instrSlot    (instrSlot),
    .instrEn      (instrEn),
    .jumpSlot     (jumpSlot),
    .jumpEn       (jumpEn),
    .hasJumps     (hasJumps),
    .error        (error),
    .jumpError    (jumpError)
  );

endmodule

`default_nettype wire

// ==== tests/predecChecker.sv ====
`timescale 1ns/1ps
`default_nettype none

module predecChecker import predecPkg::*; (
  input  logic                  clk,
  input  logic                  arstN,
  input  logic                  inValid,
  input  bundleIn               inBundle,
  input  logic                  tagValid,
  input  logic [cntWidth-1:0]   tagCount,
  input  logic [2:0]            tagFlags,
  input  logic                  outValid,
  input  predecSlot             instrSlot [instrSlots],
  input  logic [instrSlots-1:0] instrEn,
  input  predecSlot             jumpSlot  [jumpSlots],
  input  logic [jumpSlots-1:0]  jumpEn,
  input  logic                  hasJumps,
  input  logic                  error,
  input  logic                  jumpError,
  input  logic                  done,
  output int                    errorCount,
  output int                    resultsChecked,
  output int                    pendingValid
);

  typedef struct packed {
    logic                       valid;
    predecSlot [instrSlots-1:0] slots;
    logic [instrSlots-1:0]      instrEn;
    predecSlot [jumpSlots-1:0]  jumps;
    logic [jumpSlots-1:0]       jumpEn;
    logic [2:0]                 flags;    // Order is hasJumps, error, jumpError.
    logic                       tagValid;
    logic [cntWidth-1:0]        tagCount;
    logic [2:0]                 tagFlags;
  } expectT;

  expectT pipe [$];
  logic   seenResult = 1'b0;
  int     errCnt     = 0;
  int     checkedCnt = 0;
  int     pendCnt    = 0;

  assign errorCount     = errCnt;
  assign resultsChecked = checkedCnt;
  assign pendingValid   = pendCnt;

  // ******************************
  // Reference model
  // ******************************

  function automatic classVec classOf(input logic [parcelWidth-1:0] first,
                                      input logic oneParcel);
    classVec c;
    int      op;
    int      sub;
    c   = '0;
    op  = int'(first[7:0]);
    sub = int'(first[5:0]);
    if (oneParcel) begin
      if (sub <= 19) c[clsAlu] = 1'b1;
      else if (sub < 32 && sub % 2 == 1) c[clsShift] = 1'b1;
      else if (sub >= 48 && sub <= 51) c[clsJump] = 1'b1;
    end else if (op <= 39) begin
      c[clsMul] = first[2];
      c[clsAlu] = !first[2];
    end else if (op <= 45) begin
      c[clsShift] = 1'b1;
    end else if (op <= 53) begin
      c[clsAlu] = 1'b1;
    end else if (op >= 64 && op <= 159) begin
      c[clsLoad]   = (op % 2 == 0);
      c[clsStore]  = (op % 2 == 1);
      c[clsStore2] = (op % 2 == 1) && (op >= 112); // Indexed stores use both ports.
    end else if (op >= 160 && op <= 175) begin
      c[clsJump] = 1'b1;
      c[clsAlu]  = 1'b1;
    end else if (op == int'(opUncondJump)) begin
      c[clsJump] = 1'b1;
    end else if (op == int'(opIndirGroup)) begin
      c[clsJump]  = 1'b1;
      c[clsIndir] = (first[15:13] == 3'd0) || (first[15:13] == 3'd3);
    end else if (op == int'(opSys)) begin
      c[clsSys] = 1'b1;
    end
    return c;
  endfunction

  function automatic expectT predict(input logic v, input bundleIn b, input logic tv,
                                     input logic [cntWidth-1:0] tc, input logic [2:0] tf);
    expectT    e;
    predecSlot s;
    int        nInstr;
    int        nJump;
    int        p;
    int        k;
    logic      start;
    logic      complete;
    e          = '0;
    e.valid    = v;
    e.tagValid = tv;
    e.tagCount = tc;
    e.tagFlags = tf;
    nInstr     = 0;
    nJump      = 0;
    for (p = 0; p < parcelCount; p++) begin
      start = (p == int'(b.startOff));
      if ((p > 0) && (p > int'(b.startOff)) && b.endBits[p-1]) start = 1'b1;
      complete = 1'b0;
      s        = '0;
      for (k = 0; k < maxParcels; k++) begin
        if (p + k < parcelCount) begin
          s.instr[k] = b.parcels[p+k];
          complete   = complete | b.endBits[p+k];
          if (k < maxParcels - 1) s.magic[k] = b.endBits[p+k];
        end
      end
      s.off = offWidth'(p);
      s.cls = classOf(s.instr[0], s.magic[0]);
      if (start && complete) begin
        if (nInstr < instrSlots) begin
          e.slots[nInstr]   = s;
          e.instrEn[nInstr] = 1'b1;
        end
        if (s.cls[clsJump] && (nJump < jumpSlots)) begin
          e.jumps[nJump]  = s;
          e.jumpEn[nJump] = 1'b1;
        end
        if (s.cls[clsJump]) nJump++;
        nInstr++;
      end
    end
    e.flags[2] = (nJump > 0);
    e.flags[1] = (b.startOff == 4'd15) || (nInstr > instrSlots);
    e.flags[0] = (nJump > jumpSlots);
    return e;
  endfunction

  // ******************************
  // Comparison
  // ******************************

  task automatic checkValue(input string name, input logic [127:0] got,
                            input logic [127:0] exp);
    if (got !== exp) begin
      errCnt++;
      $display("Fail at %0t ns: %s got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic checkIdle();
    checkValue("outValid", 128'(outValid), '0);
    checkValue("instrEn", 128'(instrEn), '0);
    checkValue("jumpEn", 128'(jumpEn), '0);
    checkValue("hasJumps, error, jumpError", 128'({hasJumps, error, jumpError}), '0);
  endtask

  task automatic compareResult(input expectT e);
    int i;
    if (e.valid) begin
      seenResult = 1'b1;
      checkValue("outValid", 128'(outValid), 128'(1'b1));
      for (i = 0; i < instrSlots; i++) begin
        checkValue($sformatf("instrSlot[%0d]", i), 128'(instrSlot[i]), 128'(e.slots[i]));
      end
      checkValue("instrEn", 128'(instrEn), 128'(e.instrEn));
      for (i = 0; i < jumpSlots; i++) begin
        checkValue($sformatf("jumpSlot[%0d]", i), 128'(jumpSlot[i]), 128'(e.jumps[i]));
      end
      checkValue("jumpEn", 128'(jumpEn), 128'(e.jumpEn));
      checkValue("hasJumps", 128'(hasJumps), 128'(e.flags[2]));
      checkValue("error", 128'(error), 128'(e.flags[1]));
      checkValue("jumpError", 128'(jumpError), 128'(e.flags[0]));
      if (e.tagValid) begin // Hand-derived row values from the stimulus table.
        checkValue("instrEn count", 128'($countones(instrEn)), 128'(e.tagCount));
        checkValue("table flags", 128'({hasJumps, error, jumpError}), 128'(e.tagFlags));
      end
    end else if (!seenResult) begin
      checkIdle();
    end else begin
      checkValue("outValid", 128'(outValid), '0);
    end
  endtask

  // Inputs and outputs both sit still at the falling edge.
  always @(negedge clk) begin
    if (!arstN) begin
      pipe.delete();
      pendCnt = 0;
      checkIdle();
    end else begin
      pipe.push_back(predict(inValid, inBundle, tagValid, tagCount, tagFlags));
      if (inValid) pendCnt++;
      if (outValid) begin
        pendCnt--;
        checkedCnt++;
      end
      if (pipe.size() > 2) begin
        compareResult(pipe.pop_front()); // Two cycles through the pipeline.
      end else begin
        checkIdle();
      end
    end
  end

  always @(posedge done) begin
    $display("Checker summary: %0d results checked, %0d errors", checkedCnt, errCnt);
  end

endmodule

`default_nettype wire

// ==== tests/predecTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module predecTb import predecPkg::*; ();

  localparam int directedRows = 6;
  localparam int randomRows   = 40;
  localparam int drainLimit   = 20; // Cycles allowed for the pipeline to empty.

  logic                  clk;
  logic                  arstN;
  logic                  inValid;
  bundleIn               inBundle;
  logic                  tagValid;
  logic [cntWidth-1:0]   tagCount;
  logic [2:0]            tagFlags;
  logic                  done;
  logic                  outValid;
  predecSlot             instrSlot [instrSlots];
  logic [instrSlots-1:0] instrEn;
  predecSlot             jumpSlot  [jumpSlots];
  logic [jumpSlots-1:0]  jumpEn;
  logic                  hasJumps;
  logic                  error;
  logic                  jumpError;
  int                    errorCount;
  int                    resultsChecked;
  int                    pendingValid;

  bundleIn               rowBundle [directedRows];
  logic [cntWidth-1:0]   rowCount  [directedRows];
  logic [2:0]            rowFlags  [directedRows]; // Order is hasJumps, error, jumpError.

  always #2 clk = ~clk;

  predecTop uut (
    .clk(clk), .arstN(arstN), .inValid(inValid), .inBundle(inBundle),
    .outValid(outValid), .instrSlot(instrSlot), .instrEn(instrEn),
    .jumpSlot(jumpSlot), .jumpEn(jumpEn), .hasJumps(hasJumps),
    .error(error), .jumpError(jumpError)
  );

  predecChecker uCheck (
    .clk(clk), .arstN(arstN), .inValid(inValid), .inBundle(inBundle),
    .tagValid(tagValid), .tagCount(tagCount), .tagFlags(tagFlags),
    .outValid(outValid), .instrSlot(instrSlot), .instrEn(instrEn),
    .jumpSlot(jumpSlot), .jumpEn(jumpEn), .hasJumps(hasJumps),
    .error(error), .jumpError(jumpError), .done(done),
    .errorCount(errorCount), .resultsChecked(resultsChecked), .pendingValid(pendingValid)
  );

  // ******************************
  // Stimulus table
  // ******************************

  task automatic buildTable();
    int         p;
    logic [5:0] sub;
    // Fifteen short forms cycling ALU, shift and jump.
    rowBundle[0] = '0;
    for (p = 0; p < parcelCount; p++) begin
      case (p % 3)
        0:       sub = 6'd2;
        1:       sub = 6'd25;
        default: sub = 6'd49;
      endcase
      rowBundle[0].parcels[p] = {8'(p), 2'b00, sub};
    end
    rowBundle[0].endBits = '1;
    rowCount[0] = 5'd12;
    rowFlags[0] = 3'b111;
    // Lengths 2, 5, 1, 3 from offset 3 and an incomplete tail at 14.
    rowBundle[1] = '0;
    for (p = 0; p < parcelCount; p++) begin
      rowBundle[1].parcels[p] = 16'(16'h1000 + 16'h0111 * p);
    end
    rowBundle[1].endBits  = 15'h2612;
    rowBundle[1].startOff = 4'd3;
    rowCount[1] = 5'd4;
    rowFlags[1] = 3'b000;
    rowBundle[2]          = rowBundle[0];
    rowBundle[2].startOff = 4'd15;
    rowCount[2] = 5'd0;
    rowFlags[2] = 3'b010;
    // Two-parcel class mix ending in a short jump.
    rowBundle[3] = '0;
    for (p = 0; p < parcelCount; p++) begin
      rowBundle[3].parcels[p] = 16'hBEEF;
    end
    rowBundle[3].parcels[0]  = 16'h0042;
    rowBundle[3].parcels[2]  = 16'h0071;
    rowBundle[3].parcels[4]  = 16'h000C;
    rowBundle[3].parcels[6]  = 16'h00FF;
    rowBundle[3].parcels[8]  = 16'h60B6;
    rowBundle[3].parcels[10] = 16'hA0B6;
    rowBundle[3].parcels[12] = 16'h002A;
    rowBundle[3].parcels[14] = 16'h0032;
    rowBundle[3].endBits = 15'h6AAA;
    rowCount[3] = 5'd8;
    rowFlags[3] = 3'b100;
    // Five short jumps among twelve starts.
    rowBundle[4] = '0;
    for (p = 0; p < parcelCount; p++) begin
      rowBundle[4].parcels[p] = (p == 4 || p == 6 || p == 7 || p == 9 || p == 12) ?
                                16'h0130 : 16'h0007;
    end
    rowBundle[4].endBits  = '1;
    rowBundle[4].startOff = 4'd3;
    rowCount[4] = 5'd12;
    rowFlags[4] = 3'b101;
    // Three-parcel forms with four long jumps.
    rowBundle[5] = '0;
    for (p = 0; p < parcelCount; p++) begin
      rowBundle[5].parcels[p] = 16'h5A5A;
    end
    rowBundle[5].parcels[0]  = 16'h00B5;
    rowBundle[5].parcels[3]  = 16'h00A5;
    rowBundle[5].parcels[6]  = 16'h0028;
    rowBundle[5].parcels[9]  = 16'h00B6;
    rowBundle[5].parcels[12] = 16'h00AA;
    rowBundle[5].endBits = 15'h4924;
    rowCount[5] = 5'd5;
    rowFlags[5] = 3'b100;
  endtask

  function automatic bundleIn randomBundle();
    bundleIn b;
    int      p;
    for (p = 0; p < parcelCount; p++) begin
      b.parcels[p] = 16'($urandom);
    end
    b.endBits  = 15'($urandom);
    b.startOff = 4'($urandom); // Includes the illegal offset 15 now and then.
    return b;
  endfunction

  // ******************************
  // Main sequence
  // ******************************

  initial begin
    int   r;
    int   n;
    int   sent;
    logic tbFail;
    void'($urandom(32'he02a_ac5f));
    clk      = 1'b0;
    arstN    = 1'b0;
    inValid  = 1'b0;
    inBundle = '0;
    tagValid = 1'b0;
    tagCount = '0;
    tagFlags = '0;
    done     = 1'b0;
    tbFail   = 1'b0;
    sent     = 0;
    buildTable();
    repeat (3) @(posedge clk);
    #1 arstN = 1'b1;
    repeat (3) @(posedge clk); // Idle outputs are checked here.
    for (r = 0; r < directedRows + randomRows; r++) begin
      @(posedge clk);
      #1;
      inValid = 1'b1;
      if (r < directedRows) begin
        inBundle = rowBundle[r];
        tagValid = 1'b1;
        tagCount = rowCount[r];
        tagFlags = rowFlags[r];
      end else begin
        inBundle = randomBundle();
        tagValid = 1'b0;
      end
      sent++;
    end
    @(posedge clk);
    #1;
    inValid  = 1'b0;
    tagValid = 1'b0;
    for (n = 0; n < drainLimit && pendingValid != 0; n++) begin
      @(posedge clk);
    end
    if (pendingValid != 0) begin
      $display("Timeout: %0d results never appeared at the DUT outputs", pendingValid);
      tbFail = 1'b1;
    end else if (resultsChecked != sent) begin
      $display("Sent %0d bundles but only %0d results were checked", sent, resultsChecked);
      tbFail = 1'b1;
    end
    done = 1'b1;
    #1;
    if (tbFail || errorCount != 0) begin
      $display("Some tests failed");
    end else begin
      $display("All tests passed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== predecTop.f ====
src/predecPkg.sv
src/predecBoundary.sv
src/predecClassify.sv
src/slotPicker.sv
src/predecResult.sv
src/predecTop.sv
tests/predecChecker.sv
tests/predecTb.sv

// ==== Makefile ====
TOOL       = verilator
FILELIST   = predecTop.f
TOP        = predecTb
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing
OBJ_DIR    = obj_dir
LOG        = sim.log
FAIL_MSG   = Some tests failed

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
